//--- src/chrontel_pkg.sv
package chrontel_pkg;

    // Write engine states, byte position is kept in byte_sel_t
    typedef enum logic [3:0] {
        bs_idle,
        bs_bus_free,
        bs_start_hold,
        bs_bit_low,
        bs_bit_high,
        bs_ack_sample,
        bs_stop_low,
        bs_stop_setup,
        bs_nack_stop      // Aborted transfer, wait out SCL high then STOP
    } bus_state_t;

    typedef enum logic [1:0] {
        sel_dev_addr,
        sel_reg_addr,
        sel_data
    } byte_sel_t;

    // Interval the bus timer is counting
    typedef enum logic [2:0] {
        ph_start_hold,
        ph_scl_low,
        ph_scl_high,
        ph_stop_setup,
        ph_bus_free
    } timer_phase_t;

    localparam logic [7:0] DEV_ADDR = 8'hEC;  // 7-bit 0x76 with write bit
    localparam int         NUM_REGS = 6;
    localparam int         IDX_W    = 3;
    localparam int         CNT_W    = 6;      // Holds the largest count

    // Entry [1] is the register address, [0] the value, in write order
    localparam logic [1:0][7:0] REG_TABLE [NUM_REGS] = '{
        {8'h49, 8'h00},
        {8'h48, 8'h18},   // Low bits 01 would select the color bar pattern
        {8'h33, 8'hE4},
        {8'h21, 8'h09},
        {8'h1F, 8'h83},
        {8'h1C, 8'h00}
    };

    // Cycle counts at 25.2 MHz, each interval lasts count + 1 cycles
    localparam int DEF_T_LOW      = 37;
    localparam int DEF_T_HI       = 24;
    localparam int DEF_SH         = 16;
    localparam int DEF_SS         = 16;
    localparam int DEF_BUS_FREE   = 35;
    localparam int DEF_SDA_CHANGE = 7;
    localparam int DEF_INPUT_FILT = 1;

endpackage

//--- src/init_sequencer.sv
module init_sequencer (
    input  logic       clk25_2,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       xfer_done,
    input  logic       xfer_nack,
    output logic       xfer_start,
    output logic [7:0] reg_addr,
    output logic [7:0] reg_data,
    output logic       complete,
    output logic       ack_error
);
    import chrontel_pkg::*;

    typedef enum logic [1:0] {
        seq_idle,
        seq_run,     // Issue the write for the current entry
        seq_wait     // Engine busy with the write
    } seq_state_t;

    seq_state_t       state;
    logic [IDX_W-1:0] idx;
    logic             last_entry;

    assign last_entry = (idx == IDX_W'(NUM_REGS - 1));

    // Chrontel register addresses are sent with bit 7 set
    assign reg_addr = REG_TABLE[idx][1] | 8'h80;
    assign reg_data = REG_TABLE[idx][0];

    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            state      <= seq_idle;
            idx        <= '0;
            xfer_start <= 1'b0;
            complete   <= 1'b0;
            ack_error  <= 1'b0;
        end else begin
            xfer_start <= 1'b0;
            case (state)
                seq_idle: begin
                    if (enable) begin
                        complete  <= 1'b0;   // Rerun starts from a clean status
                        ack_error <= 1'b0;
                        idx       <= '0;
                        state     <= seq_run;
                    end
                end

                seq_run: begin
                    xfer_start <= 1'b1;
                    state      <= seq_wait;
                end

                seq_wait: begin
                    if (xfer_done) begin
                        ack_error <= ack_error | xfer_nack;  // Sticky
                        if (last_entry) begin
                            complete <= 1'b1;
                            state    <= seq_idle;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= seq_run;
                        end
                    end
                end

                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

endmodule

//--- src/i2c_write_engine.sv
module i2c_write_engine (
    input  logic                       clk25_2,
    input  logic                       rst_n,
    input  logic                       xfer_start,
    input  logic [7:0]                 reg_addr,
    input  logic [7:0]                 reg_data,
    input  logic                       phase_done,
    input  logic                       sda_change,
    input  logic                       sda_filt,
    output chrontel_pkg::timer_phase_t phase,
    output logic                       timer_run,
    output logic                       scl_drive_low,
    output logic                       sda_drive_low,
    output logic                       xfer_done,
    output logic                       xfer_nack
);
    import chrontel_pkg::*;

    bus_state_t state;
    byte_sel_t  byte_sel;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic [7:0] addr_q;
    logic [7:0] data_q;
    logic       closing;     // STOP sent, next gap ends the transfer
    logic       nack_q;
    logic       ack_bit;
    logic       after_ack;

    assign ack_bit   = (bit_cnt == 4'd8);  // Ninth clock of a byte
    assign after_ack = (bit_cnt == 4'd0);  // Only true in bit_high right after an ACK

    always_comb begin
        case (state)
            bs_start_hold:                           phase = ph_start_hold;
            bs_bit_low, bs_stop_low:                 phase = ph_scl_low;
            bs_bit_high, bs_ack_sample, bs_nack_stop: phase = ph_scl_high;
            bs_stop_setup:                           phase = ph_stop_setup;
            default:                                 phase = ph_bus_free;
        endcase
    end

    // Dropping run in the last cycle of a phase restarts the count at zero
    assign timer_run = (state != bs_idle) && !phase_done;

    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            state         <= bs_idle;
            byte_sel      <= sel_dev_addr;
            bit_cnt       <= '0;
            closing       <= 1'b0;
            nack_q        <= 1'b0;
            scl_drive_low <= 1'b0;
            sda_drive_low <= 1'b0;
            xfer_done     <= 1'b0;
            xfer_nack     <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            xfer_nack <= 1'b0;
            case (state)
                bs_idle: begin
                    if (xfer_start) begin
                        closing <= 1'b0;
                        nack_q  <= 1'b0;
                        state   <= bs_bus_free;
                    end
                end

                bs_bus_free: begin
                    if (phase_done) begin
                        if (closing) begin
                            xfer_done <= 1'b1;
                            xfer_nack <= nack_q;
                            state     <= bs_idle;
                        end else begin
                            sda_drive_low <= 1'b1;   // START, SCL still high
                            byte_sel      <= sel_dev_addr;
                            bit_cnt       <= '0;
                            state         <= bs_start_hold;
                        end
                    end
                end

                bs_start_hold: begin
                    if (phase_done) begin
                        scl_drive_low <= 1'b1;
                        state         <= bs_bit_low;
                    end
                end

                bs_bit_low: begin
                    if (sda_change) begin
                        // Release SDA on the ACK clock so the slave can answer
                        sda_drive_low <= ack_bit ? 1'b0 : !shreg[7];
                    end
                    if (phase_done) begin
                        scl_drive_low <= 1'b0;
                        if (ack_bit) begin
                            bit_cnt <= '0;
                            state   <= bs_ack_sample;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= bs_bit_high;
                        end
                    end
                end

                bs_bit_high: begin
                    if (phase_done) begin
                        scl_drive_low <= 1'b1;
                        if (after_ack && byte_sel == sel_data) begin
                            state <= bs_stop_low;
                        end else begin
                            if (after_ack) begin
                                byte_sel <= (byte_sel == sel_dev_addr) ? sel_reg_addr
                                                                        : sel_data;
                            end
                            state <= bs_bit_low;
                        end
                    end
                end

                bs_ack_sample: begin
                    if (sda_filt) begin                 // NACK
                        nack_q <= 1'b1;
                        state  <= bs_nack_stop;
                    end else begin
                        state <= bs_bit_high;
                    end
                end

                bs_nack_stop: begin
                    if (phase_done) begin
                        scl_drive_low <= 1'b1;
                        state         <= bs_stop_low;
                    end
                end

                bs_stop_low: begin
                    if (sda_change) begin
                        sda_drive_low <= 1'b1;
                    end
                    if (phase_done) begin
                        scl_drive_low <= 1'b0;
                        state         <= bs_stop_setup;
                    end
                end

                bs_stop_setup: begin
                    if (phase_done) begin
                        sda_drive_low <= 1'b0;   // STOP, SDA rises with SCL high
                        closing       <= 1'b1;
                        state         <= bs_bus_free;
                    end
                end

                default: begin
                    state <= bs_idle;
                end
            endcase
        end
    end

    // Byte datapath
    always_ff @(posedge clk25_2) begin
        if (state == bs_idle && xfer_start) begin
            addr_q <= reg_addr;
            data_q <= reg_data;
        end
        if (state == bs_bus_free && phase_done && !closing) begin
            shreg <= DEV_ADDR;
        end else if (state == bs_bit_low && sda_change && !ack_bit) begin
            shreg <= {shreg[6:0], 1'b0};           // MSB first
        end else if (state == bs_bit_high && phase_done && after_ack) begin
            shreg <= (byte_sel == sel_dev_addr) ? addr_q : data_q;
        end
    end

endmodule

//--- src/i2c_bus_timer.sv
module i2c_bus_timer #(
    parameter int T_LOW_COUNT      = chrontel_pkg::DEF_T_LOW,
    parameter int T_HI_COUNT       = chrontel_pkg::DEF_T_HI,
    parameter int SH_COUNT         = chrontel_pkg::DEF_SH,
    parameter int SS_COUNT         = chrontel_pkg::DEF_SS,
    parameter int BUS_FREE_COUNT   = chrontel_pkg::DEF_BUS_FREE,
    parameter int SDA_CHANGE_COUNT = chrontel_pkg::DEF_SDA_CHANGE
) (
    input  logic                       clk25_2,
    input  logic                       rst_n,
    input  chrontel_pkg::timer_phase_t phase,
    input  logic                       timer_run,
    output logic                       phase_done,
    output logic                       sda_change
);
    import chrontel_pkg::*;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] limit;

    // Terminal count of the running interval
    always_comb begin
        case (phase)
            ph_start_hold: limit = CNT_W'(SH_COUNT);
            ph_scl_low:    limit = CNT_W'(T_LOW_COUNT);
            ph_scl_high:   limit = CNT_W'(T_HI_COUNT);
            ph_stop_setup: limit = CNT_W'(SS_COUNT);
            default:       limit = CNT_W'(BUS_FREE_COUNT);
        endcase
    end

    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!timer_run) begin
            cnt <= '0;            // Held at zero between phases
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign phase_done = (cnt == limit);

    // SDA may only move a fixed hold time after SCL has fallen
    assign sda_change = (phase == ph_scl_low) && (cnt == CNT_W'(SDA_CHANGE_COUNT));

endmodule

//--- src/i2c_line_io.sv
module i2c_line_io #(
    parameter int INPUT_FILT = chrontel_pkg::DEF_INPUT_FILT
) (
    input  logic clk25_2,
    input  logic rst_n,
    input  logic scl_drive_low,
    input  logic sda_drive_low,
    output tri   i2c_scl,
    inout  tri   i2c_sda,
    output logic sda_filt
);

    logic [INPUT_FILT-1:0] sda_sr;   // Last INPUT_FILT samples of the pad

    // Open drain, the external pull-ups supply the high level
    assign i2c_scl = scl_drive_low ? 1'b0 : 1'bz;
    assign i2c_sda = sda_drive_low ? 1'b0 : 1'bz;

    // Spike filter, the output follows only once every sample agrees
    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            sda_sr   <= '1;         // Idle bus reads high
            sda_filt <= 1'b1;
        end else begin
            sda_sr <= INPUT_FILT'({sda_sr, i2c_sda});
            if (&sda_sr) begin
                sda_filt <= 1'b1;
            end else if (~|sda_sr) begin
                sda_filt <= 1'b0;
            end
        end
    end

endmodule

//--- src/chrontel_init_top.sv
module chrontel_init_top #(
    parameter int T_LOW_COUNT      = chrontel_pkg::DEF_T_LOW,
    parameter int T_HI_COUNT       = chrontel_pkg::DEF_T_HI,
    parameter int SH_COUNT         = chrontel_pkg::DEF_SH,
    parameter int SS_COUNT         = chrontel_pkg::DEF_SS,
    parameter int BUS_FREE_COUNT   = chrontel_pkg::DEF_BUS_FREE,
    parameter int SDA_CHANGE_COUNT = chrontel_pkg::DEF_SDA_CHANGE,
    parameter int INPUT_FILT       = chrontel_pkg::DEF_INPUT_FILT
) (
    input  logic clk25_2,
    input  logic rst_n,
    input  logic enable,
    output logic complete,
    output logic ack_error,
    output tri   i2c_scl,
    inout  tri   i2c_sda
);
    import chrontel_pkg::*;

    logic         xfer_start;
    logic [7:0]   reg_addr;
    logic [7:0]   reg_data;
    logic         xfer_done;
    logic         xfer_nack;
    timer_phase_t phase;
    logic         timer_run;
    logic         phase_done;
    logic         sda_change;
    logic         scl_drive_low;
    logic         sda_drive_low;
    logic         sda_filt;

    init_sequencer seq_i (
        .clk25_2    (clk25_2),
        .rst_n      (rst_n),
        .enable     (enable),
        .xfer_done  (xfer_done),
        .xfer_nack  (xfer_nack),
        .xfer_start (xfer_start),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .complete   (complete),
        .ack_error  (ack_error)
    );

    i2c_write_engine engine_i (
        .clk25_2       (clk25_2),
        .rst_n         (rst_n),
        .xfer_start    (xfer_start),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .phase_done    (phase_done),
        .sda_change    (sda_change),
        .sda_filt      (sda_filt),
        .phase         (phase),
        .timer_run     (timer_run),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low),
        .xfer_done     (xfer_done),
        .xfer_nack     (xfer_nack)
    );

    i2c_bus_timer #(
        .T_LOW_COUNT      (T_LOW_COUNT),
        .T_HI_COUNT       (T_HI_COUNT),
        .SH_COUNT         (SH_COUNT),
        .SS_COUNT         (SS_COUNT),
        .BUS_FREE_COUNT   (BUS_FREE_COUNT),
        .SDA_CHANGE_COUNT (SDA_CHANGE_COUNT)
    ) timer_i (
        .clk25_2    (clk25_2),
        .rst_n      (rst_n),
        .phase      (phase),
        .timer_run  (timer_run),
        .phase_done (phase_done),
        .sda_change (sda_change)
    );

    i2c_line_io #(
        .INPUT_FILT (INPUT_FILT)
    ) line_io_i (
        .clk25_2       (clk25_2),
        .rst_n         (rst_n),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low),
        .i2c_scl       (i2c_scl),
        .i2c_sda       (i2c_sda),
        .sda_filt      (sda_filt)
    );

endmodule

//--- verif/chrontel_init_assertions.sv
module chrontel_init_assertions #(
    parameter int T_LOW_COUNT    = chrontel_pkg::DEF_T_LOW,
    parameter int T_HI_COUNT     = chrontel_pkg::DEF_T_HI,
    parameter int BUS_FREE_COUNT = chrontel_pkg::DEF_BUS_FREE
) (
    input logic clk25_2,
    input logic rst_n,
    input logic enable,
    input logic complete,
    input logic ack_error,
    input logic i2c_scl,
    input logic i2c_sda
);
    import chrontel_pkg::*;

    localparam int LEN_MAX = 1000;   // Saturation point of the period counters

    int         fail_cnt = 0;
    logic       seen_enable;
    logic       scl_q;
    logic       sda_q;
    logic       complete_q;
    logic       ack_error_q;
    logic       in_xfer_q;
    int         scl_len;
    int         idle_len;
    int         byte_total_q;
    int         done_runs;
    logic       start_evt;
    logic       stop_evt;
    logic       byte_evt;

    // View of the slave model
    int         start_cnt;
    int         stop_cnt;
    int         byte_total;
    int         byte_pos;
    int         xfer_bytes;
    int         bit_pos;
    int         nack_pos;
    logic       in_xfer;
    logic       nack_in_run;
    logic [7:0] last_byte;

    assign start_cnt   = tb_chrontel_init.slave_i.start_cnt;
    assign stop_cnt    = tb_chrontel_init.slave_i.stop_cnt;
    assign byte_total  = tb_chrontel_init.slave_i.byte_total;
    assign byte_pos    = tb_chrontel_init.slave_i.byte_pos;
    assign xfer_bytes  = tb_chrontel_init.slave_i.xfer_bytes;
    assign bit_pos     = tb_chrontel_init.slave_i.bit_pos;
    assign nack_pos    = tb_chrontel_init.slave_i.nack_pos;
    assign in_xfer     = tb_chrontel_init.slave_i.in_xfer;
    assign nack_in_run = tb_chrontel_init.slave_i.nack_in_run;
    assign last_byte   = tb_chrontel_init.slave_i.last_byte;

    // SDA moving while SCL stays high
    assign start_evt = scl_q && i2c_scl && sda_q && !i2c_sda;
    assign stop_evt  = scl_q && i2c_scl && !sda_q && i2c_sda;
    assign byte_evt  = (byte_total != byte_total_q);

    // Device address, register address with bit 7 set, then the value
    function automatic logic [7:0] expected_byte(int xfer, int pos);
        case (pos)
            0:       return 8'hEC;
            1:       return {1'b1, REG_TABLE[xfer][1][6:0]};
            default: return REG_TABLE[xfer][0];
        endcase
    endfunction

    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            seen_enable  <= 1'b0;
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            complete_q   <= 1'b0;
            ack_error_q  <= 1'b0;
            in_xfer_q    <= 1'b0;
            scl_len      <= LEN_MAX;
            idle_len     <= LEN_MAX;
            byte_total_q <= 0;
            done_runs    <= 0;
        end else begin
            seen_enable  <= seen_enable | enable;
            scl_q        <= i2c_scl;
            sda_q        <= i2c_sda;
            complete_q   <= complete;
            ack_error_q  <= ack_error;
            in_xfer_q    <= in_xfer;
            byte_total_q <= byte_total;
            if (i2c_scl != scl_q) begin
                scl_len <= 1;
            end else if (scl_len < LEN_MAX) begin
                scl_len <= scl_len + 1;
            end
            if (stop_evt) begin
                idle_len <= 1;
            end else if (idle_len < LEN_MAX) begin
                idle_len <= idle_len + 1;
            end
            if (complete && !complete_q) begin
                done_runs <= done_runs + 1;
            end
        end
    end

    idle_before_enable: assert property (@(posedge clk25_2) disable iff (!rst_n)
        !seen_enable |-> i2c_scl && i2c_sda && !complete && !ack_error)
        else begin
            fail_cnt++;
            $error("Bus or status not idle before enable");
        end

    byte_value: assert property (@(posedge clk25_2) disable iff (!rst_n)
        byte_evt |-> last_byte == expected_byte((start_cnt - 1) % NUM_REGS, byte_pos))
        else begin
            fail_cnt++;
            $error("FAIL i2c_sda byte: got %h expected %h", last_byte,
                   expected_byte((start_cnt - 1) % NUM_REGS, byte_pos));
        end

    // The SCL rise of the STOP itself reaches the slave as one more clock
    stop_after_bytes: assert property (@(posedge clk25_2) disable iff (!rst_n)
        stop_evt |-> in_xfer_q && bit_pos == 1
                     && xfer_bytes == ((nack_pos >= 0) ? nack_pos + 1 : 3))
        else begin
            fail_cnt++;
            $error("STOP came at the wrong point of the transaction (%0d bytes)", xfer_bytes);
        end

    start_when_idle: assert property (@(posedge clk25_2) disable iff (!rst_n)
        start_evt |-> !in_xfer_q && idle_len >= BUS_FREE_COUNT + 1)
        else begin
            fail_cnt++;
            $error("START inside a transaction or after a short bus-free gap");
        end

    scl_high_len: assert property (@(posedge clk25_2) disable iff (!rst_n)
        scl_q && !i2c_scl |-> scl_len >= T_HI_COUNT + 1)
        else begin
            fail_cnt++;
            $error("SCL high period too short, %0d cycles", scl_len);
        end

    scl_low_len: assert property (@(posedge clk25_2) disable iff (!rst_n)
        !scl_q && i2c_scl |-> scl_len >= T_LOW_COUNT + 1)
        else begin
            fail_cnt++;
            $error("SCL low period too short, %0d cycles", scl_len);
        end

    complete_count: assert property (@(posedge clk25_2) disable iff (!rst_n)
        complete && !complete_q |-> stop_cnt == NUM_REGS * (done_runs + 1)
                                    && start_cnt == stop_cnt)
        else begin
            fail_cnt++;
            $error("complete rose after %0d STOPs", stop_cnt);
        end

    complete_status: assert property (@(posedge clk25_2) disable iff (!rst_n)
        complete && !complete_q |-> ack_error == nack_in_run)
        else begin
            fail_cnt++;
            $error("FAIL ack_error: got %h expected %h", ack_error, nack_in_run);
        end

    bus_idle_when_done: assert property (@(posedge clk25_2) disable iff (!rst_n)
        complete |-> i2c_scl && i2c_sda)
        else begin
            fail_cnt++;
            $error("Bus active while complete is high");
        end

    clear_on_accept: assert property (@(posedge clk25_2) disable iff (!rst_n)
        enable && complete |=> !complete && !ack_error)
        else begin
            fail_cnt++;
            $error("New enable did not clear complete and ack_error");
        end

    ack_error_cause: assert property (@(posedge clk25_2) disable iff (!rst_n)
        ack_error && !ack_error_q |-> nack_in_run)
        else begin
            fail_cnt++;
            $error("ack_error rose without a NACK from the slave");
        end

endmodule

//--- verif/tb_chrontel_init.sv
module i2c_slave_model (
    input  logic scl,
    inout  tri   sda,
    input  int   nack_xfer,   // Transaction within a run that gets a NACK
    input  int   nack_byte    // Byte position in that transaction
);
    import chrontel_pkg::*;

    logic       pull_low = 1'b0;
    logic       scl_prev = 1'b1;
    logic       sda_prev = 1'b1;
    logic       in_xfer = 1'b0;
    logic       nack_now = 1'b0;
    logic       nack_in_run = 1'b0;
    int         start_cnt = 0;
    int         stop_cnt = 0;
    int         byte_total = 0;
    int         byte_pos = 0;
    int         xfer_bytes = 0;
    int         bit_pos = 0;
    int         nack_pos = -1;
    logic [7:0] shift_in = 8'h00;
    logic [7:0] last_byte = 8'h00;

    assign sda = pull_low ? 1'b0 : 1'bz;

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda === 1'b0) begin
            if (start_cnt % NUM_REGS == 0) begin
                nack_in_run = 1'b0;     // First write of a run
            end
            start_cnt++;
            in_xfer    = 1'b1;
            bit_pos    = 0;
            xfer_bytes = 0;
            nack_pos   = -1;
            nack_now   = 1'b0;
        end else if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0 && sda === 1'b1) begin
            stop_cnt++;
            in_xfer = 1'b0;
        end else if (scl === 1'b1 && scl_prev === 1'b0 && in_xfer) begin
            if (bit_pos < 8) begin
                shift_in = {shift_in[6:0], sda};   // MSB first
                bit_pos++;
                if (bit_pos == 8) begin
                    last_byte  = shift_in;
                    byte_pos   = xfer_bytes;
                    xfer_bytes++;
                    byte_total++;
                    nack_now = ((start_cnt - 1) % NUM_REGS == nack_xfer)
                               && (byte_pos == nack_byte);
                    if (nack_now) begin
                        nack_pos    = byte_pos;
                        nack_in_run = 1'b1;
                    end
                end
            end else begin
                bit_pos = 0;    // Ninth clock carries the acknowledge
            end
        end
        scl_prev = scl;
        sda_prev = sda;
    end

    // Acknowledge drive moves only while SCL is low
    always @(negedge scl) begin
        #2;
        pull_low = in_xfer && bit_pos == 8 && !nack_now;
    end

endmodule

module tb_chrontel_init;
    import chrontel_pkg::*;

    localparam int T_LOW_COUNT      = DEF_T_LOW;
    localparam int T_HI_COUNT       = DEF_T_HI;
    localparam int SH_COUNT         = DEF_SH;
    localparam int SS_COUNT         = DEF_SS;
    localparam int BUS_FREE_COUNT   = DEF_BUS_FREE;
    localparam int SDA_CHANGE_COUNT = DEF_SDA_CHANGE;
    localparam int INPUT_FILT       = DEF_INPUT_FILT;

    // One write is two bus-free gaps, START, 27 clocks and STOP
    localparam int XFER_CYCLES = 2 * (BUS_FREE_COUNT + 1) + (SH_COUNT + 1)
                               + 27 * (T_LOW_COUNT + T_HI_COUNT + 2)
                               + (T_LOW_COUNT + 1) + (SS_COUNT + 1) + 4;
    localparam int RUN_CYCLES     = NUM_REGS * XFER_CYCLES;
    localparam int TIMEOUT_CYCLES = 3 * RUN_CYCLES + 5000;   // Two runs plus margin

    logic clk25_2;
    logic rst_n;
    logic enable;
    logic complete;
    logic ack_error;
    tri   i2c_scl;
    tri   i2c_sda;
    int   nack_xfer;
    int   nack_byte;
    int   cycle_cnt = 0;
    int   timeouts = 0;

    pullup (i2c_scl);
    pullup (i2c_sda);

    chrontel_init_top #(
        .T_LOW_COUNT      (T_LOW_COUNT),
        .T_HI_COUNT       (T_HI_COUNT),
        .SH_COUNT         (SH_COUNT),
        .SS_COUNT         (SS_COUNT),
        .BUS_FREE_COUNT   (BUS_FREE_COUNT),
        .SDA_CHANGE_COUNT (SDA_CHANGE_COUNT),
        .INPUT_FILT       (INPUT_FILT)
    ) dut_i (
        .clk25_2   (clk25_2),
        .rst_n     (rst_n),
        .enable    (enable),
        .complete  (complete),
        .ack_error (ack_error),
        .i2c_scl   (i2c_scl),
        .i2c_sda   (i2c_sda)
    );

    i2c_slave_model slave_i (
        .scl       (i2c_scl),
        .sda       (i2c_sda),
        .nack_xfer (nack_xfer),
        .nack_byte (nack_byte)
    );

    bind chrontel_init_top chrontel_init_assertions #(
        .T_LOW_COUNT    (T_LOW_COUNT),
        .T_HI_COUNT     (T_HI_COUNT),
        .BUS_FREE_COUNT (BUS_FREE_COUNT)
    ) asserts_i (
        .clk25_2   (clk25_2),
        .rst_n     (rst_n),
        .enable    (enable),
        .complete  (complete),
        .ack_error (ack_error),
        .i2c_scl   (i2c_scl),
        .i2c_sda   (i2c_sda)
    );

    initial clk25_2 = 1'b0;
    always #20 clk25_2 = ~clk25_2;

    task automatic report_counts();
        $display("Error counts: assertion failures %0d, timeouts %0d",
                 dut_i.asserts_i.fail_cnt, timeouts);
    endtask

    // One-cycle enable pulse
    task automatic start_sequence(input int nack_at_xfer, input int nack_at_byte);
        @(posedge clk25_2);
        #2;
        nack_xfer = nack_at_xfer;
        nack_byte = nack_at_byte;
        enable    = 1'b1;
        @(posedge clk25_2);
        #2 enable = 1'b0;
    endtask

    task automatic wait_for_complete();
        @(negedge clk25_2);
        while (complete) @(negedge clk25_2);
        while (!complete) @(negedge clk25_2);
    endtask

    always @(posedge clk25_2) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            timeouts = timeouts + 1;
            $display("Timeout: sequence did not complete within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        enable    = 1'b0;
        rst_n     = 1'b0;
        nack_xfer = -1;
        nack_byte = -1;
        repeat (10) @(posedge clk25_2);
        #2 rst_n = 1'b1;
        repeat (100) @(posedge clk25_2);    // Bus must stay idle here

        start_sequence(-1, -1);             // All six writes acknowledged
        wait_for_complete();
        repeat (200) @(posedge clk25_2);

        start_sequence(2, 1);               // Register address of third write refused
        wait_for_complete();
        repeat (200) @(posedge clk25_2);

        // Rerun, status clears at acceptance
        start_sequence(-1, -1);
        repeat (20) @(posedge clk25_2);

        report_counts();
        if (dut_i.asserts_i.fail_cnt == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
src/chrontel_pkg.sv
src/init_sequencer.sv
src/i2c_write_engine.sv
src/i2c_bus_timer.sv
src/i2c_line_io.sv
src/chrontel_init_top.sv
verif/chrontel_init_assertions.sv
verif/tb_chrontel_init.sv

//--- Makefile
TOP := tb_chrontel_init
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
